// ==== common/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

	import wb_pkg::*;

	// one instruction as it leaves issue
	// sub only matters to the add/sub unit
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		logic  sub;
		word_t a;
		word_t b;
	} issue_t;

endpackage

`default_nettype wire

// ==== common/wb_macros.svh ====
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define WORD_WIDTH 32
`define TAG_WIDTH 4

//////////////////////////////////////////////////////////////////////
// unit latencies in edges from issue to result bus
//////////////////////////////////////////////////////////////////////

`define MUL_LATENCY 4
`define ADD_LATENCY 2
`define MOV_LATENCY 1

// one chain entry for every cycle of the slowest unit
`define RSV_DEPTH `MUL_LATENCY

`endif

// ==== common/wb_pkg.sv ====
`include "wb_macros.svh"
`default_nettype none

package wb_pkg;

	// data word and ROB tag
	typedef logic [`WORD_WIDTH-1:0] word_t;
	typedef logic [`TAG_WIDTH-1:0] tag_t;

	// unit that owns a result bus slot
	typedef enum logic [1:0] {
		SRC_MUL     = 2'd0,
		SRC_ADD_SUB = 2'd1,
		SRC_MOV     = 2'd2
	} wb_src_t;

	// one reserved bus cycle
	typedef struct packed {
		logic    valid;
		tag_t    tag;
		wb_src_t src;
	} rsv_entry_t;

	// the result bus
	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t data;
	} wb_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+common
common/wb_pkg.sv
common/issue_pkg.sv
logic/mul_pipe.sv
logic/add_sub_pipe.sv
wb_sched/wb_reservation.sv
logic/wb_bus.sv
tb/tb_wb_bus.sv

// ==== logic/add_sub_pipe.sv ====
`include "wb_macros.svh"
`default_nettype none

module add_sub_pipe
	import wb_pkg::*;
(
	input  logic  clk,
	input  word_t a,
	input  word_t b,
	input  logic  sub,
	output word_t sum
);
	localparam int HALF = `WORD_WIDTH / 2;

	logic [HALF-1:0] b_lo_x;
	logic [HALF-1:0] b_hi_x;
	logic [HALF:0]   low_sum;
	logic [HALF-1:0] low_1;
	logic            carry_1;
	logic [HALF-1:0] a_hi_1;
	logic [HALF-1:0] b_hi_1;
	logic [HALF-1:0] high_sum;

	// subtract as a plus inverted b plus one
	assign b_lo_x = sub ? ~b[HALF-1:0] : b[HALF-1:0];
	assign b_hi_x = sub ? ~b[`WORD_WIDTH-1:HALF] : b[`WORD_WIDTH-1:HALF];

	assign low_sum = {1'b0, a[HALF-1:0]} + {1'b0, b_lo_x} + {{HALF{1'b0}}, sub};

	// low half done, carry held for the upper half
	always_ff @(posedge clk) begin
		low_1   <= low_sum[HALF-1:0];
		carry_1 <= low_sum[HALF];
		a_hi_1  <= a[`WORD_WIDTH-1:HALF];
		b_hi_1  <= b_hi_x;
	end

	assign high_sum = a_hi_1 + b_hi_1 + {{(HALF-1){1'b0}}, carry_1};

	// carry out of the top is dropped
	always_ff @(posedge clk) begin
		sum <= {high_sum, low_1};
	end
endmodule

`default_nettype wire

// ==== logic/mul_pipe.sv ====
`include "wb_macros.svh"
`default_nettype none

module mul_pipe
	import wb_pkg::*;
(
	input  logic  clk,
	input  word_t a,
	input  word_t b,
	output word_t product
);
	localparam int HALF = `WORD_WIDTH / 2;

	// operand halves
	logic [HALF-1:0] a_lo_1;
	logic [HALF-1:0] a_hi_1;
	logic [HALF-1:0] b_lo_1;
	logic [HALF-1:0] b_hi_1;

	// only the low halves of the cross terms matter
	word_t           ll_2;
	logic [HALF-1:0] lh_2;
	logic [HALF-1:0] hl_2;

	// cross terms folded together
	word_t           ll_3;
	logic [HALF-1:0] cross_3;

	//////////////////////////////////////////////////////////////////////
	// split and multiply
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		a_lo_1 <= a[HALF-1:0];
		a_hi_1 <= a[`WORD_WIDTH-1:HALF];
		b_lo_1 <= b[HALF-1:0];
		b_hi_1 <= b[`WORD_WIDTH-1:HALF];
	end

	// hi*hi lands entirely above the low word
	always_ff @(posedge clk) begin
		ll_2 <= a_lo_1 * b_lo_1;
		lh_2 <= a_lo_1 * b_hi_1;
		hl_2 <= a_hi_1 * b_lo_1;
	end

	//////////////////////////////////////////////////////////////////////
	// sum the partial products
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		ll_3    <= ll_2;
		cross_3 <= lh_2 + hl_2;
	end

	always_ff @(posedge clk) begin
		product <= ll_3 + {cross_3, {HALF{1'b0}}};
	end
endmodule

`default_nettype wire

// ==== logic/wb_bus.sv ====
`default_nettype none

module wb_bus
	import wb_pkg::*;
	import issue_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   flush,
	input  issue_t mul_issue,
	input  issue_t add_issue,
	input  issue_t mov_issue,
	output logic   add_ready,
	output logic   mov_ready,
	output wb_t    wb
);
	word_t      mul_result;
	word_t      add_sub_result;
	word_t      mov_result;
	rsv_entry_t head;

	//////////////////////////////////////////////////////////////////////
	// fixed latency units
	//////////////////////////////////////////////////////////////////////

	// units run every cycle, the scheduler decides what is kept
	mul_pipe u_mul_pipe (
		.clk,
		.a       (mul_issue.a),
		.b       (mul_issue.b),
		.product (mul_result)
	);

	add_sub_pipe u_add_sub_pipe (
		.clk,
		.a   (add_issue.a),
		.b   (add_issue.b),
		.sub (add_issue.sub),
		.sum (add_sub_result)
	);

	// move is a single register stage
	always_ff @(posedge clk) begin
		mov_result <= mov_issue.a;
	end

	//////////////////////////////////////////////////////////////////////
	// scheduler
	//////////////////////////////////////////////////////////////////////

	wb_reservation u_wb_reservation (
		.clk,
		.reset,
		.flush,
		.mul_issue,
		.add_issue,
		.mov_issue,
		.add_ready,
		.mov_ready,
		.head
	);

	//////////////////////////////////////////////////////////////////////
	// result bus
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		wb.valid = head.valid;
		wb.tag   = head.tag;
		case (head.src)
			SRC_MUL: begin
				wb.data = mul_result;
			end
			SRC_ADD_SUB: begin
				wb.data = add_sub_result;
			end
			SRC_MOV: begin
				wb.data = mov_result;
			end
			default: begin
				wb.data = '0;
			end
		endcase
	end
endmodule

`default_nettype wire

// ==== tb/tb_wb_bus.sv ====
`include "wb_macros.svh"
`default_nettype none

module tb_wb_bus
	import wb_pkg::*;
	import issue_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RETRY_LIMIT = 8;
	localparam int DRAIN_LIMIT = 4 * `MUL_LATENCY;

	logic   clk;
	logic   reset;
	logic   flush;
	issue_t mul_in;
	issue_t add_in;
	issue_t mov_in;
	logic   add_ready;
	logic   mov_ready;
	wb_t    wb;

	// expected bus values, keyed by the edge that opens their bus cycle
	wb_t   expected[int];
	int    cycle;
	logic  add_taken;
	logic  mov_taken;
	string test_name;
	int    test_errors;
	int    errors;
	int    checks;
	int    tests;
	logic  timed_out;

	wb_bus u_wb_bus (
		.clk,
		.reset,
		.flush,
		.mul_issue (mul_in),
		.add_issue (add_in),
		.mov_issue (mov_in),
		.add_ready,
		.mov_ready,
		.wb
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic word_t expected_result(input wb_src_t src, input issue_t op);
		case (src)
			SRC_MUL: return op.a * op.b;
			SRC_ADD_SUB: return op.sub ? op.a - op.b : op.a + op.b;
			default: return op.a;
		endcase
	endfunction

	function automatic wb_t expected_wb(input wb_src_t src, input issue_t op);
		wb_t w;
		w.valid = 1'b1;
		w.tag   = op.tag;
		w.data  = expected_result(src, op);
		return w;
	endfunction

	function automatic issue_t make_issue(input tag_t tag, input logic sub,
			input word_t a, input word_t b);
		issue_t op;
		op.valid = 1'b1;
		op.tag   = tag;
		op.sub   = sub;
		op.a     = a;
		op.b     = b;
		return op;
	endfunction

	function automatic issue_t random_issue();
		return make_issue(tag_t'($urandom_range(15, 0)), $urandom_range(1, 0) == 1,
			$urandom, $urandom);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	function automatic string format_wb(input wb_t w);
		return $sformatf("valid %b tag %h data %h", w.valid, w.tag, w.data);
	endfunction

	task automatic check_wb(input wb_t exp_wb, input wb_t act_wb);
		logic mismatch;
		checks++;
		// an empty cycle only needs valid low
		mismatch = exp_wb.valid ? (act_wb !== exp_wb) : (act_wb.valid !== 1'b0);
		if (mismatch) begin
			errors++;
			test_errors++;
			$display("FAILED %s: wb expected %s, actual %s", test_name,
				format_wb(exp_wb), format_wb(act_wb));
		end
	endtask

	task automatic check_ready(input string what, input logic exp_ready, input logic act_ready);
		checks++;
		if (act_ready !== exp_ready) begin
			errors++;
			test_errors++;
			$display("FAILED %s: %s expected %b, actual %b", test_name, what,
				exp_ready, act_ready);
		end
	endtask

	// one bus slot per cycle, claimed at issue by latency
	initial begin : compare_proc
		int   mov_due;
		int   add_due;
		int   mul_due;
		logic add_free;
		logic mov_free;
		forever begin
			@(posedge clk);
			cycle = cycle + 1;
			if (reset) begin
				expected.delete();
				add_taken = 1'b0;
				mov_taken = 1'b0;
			end else begin
				if (expected.exists(cycle - 1)) begin
					check_wb(expected[cycle - 1], wb);
					expected.delete(cycle - 1);
				end else begin
					check_wb('0, wb);
				end
				mov_due  = cycle + `MOV_LATENCY - 1;
				add_due  = cycle + `ADD_LATENCY - 1;
				mul_due  = cycle + `MUL_LATENCY - 1;
				add_free = !expected.exists(add_due);
				mov_free = !expected.exists(mov_due);
				check_ready("add_ready", add_free, add_ready);
				check_ready("mov_ready", mov_free, mov_ready);
				add_taken = add_in.valid && add_free;
				mov_taken = mov_in.valid && mov_free;
				if (mul_in.valid) begin
					expected[mul_due] = expected_wb(SRC_MUL, mul_in);
				end
				if (add_taken) begin
					expected[add_due] = expected_wb(SRC_ADD_SUB, add_in);
				end
				if (mov_taken) begin
					expected[mov_due] = expected_wb(SRC_MOV, mov_in);
				end
				if (flush) begin
					expected.delete();
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	task automatic clear_inputs();
		mul_in = '0;
		add_in = '0;
		mov_in = '0;
	endtask

	task automatic next_cycle();
		@(negedge clk);
	endtask

	task automatic note_timeout(input string what);
		$display("%s: timed out while %s", test_name, what);
		timed_out = 1'b1;
	endtask

	task automatic drain();
		int waited = 0;
		clear_inputs();
		while (expected.size() != 0 && !timed_out) begin
			if (waited == DRAIN_LIMIT) begin
				note_timeout("waiting for results to reach the bus");
				return;
			end
			waited++;
			next_cycle();
		end
	endtask

	// refused issues are held and retried
	task automatic offer_add(input issue_t op);
		int tries = 0;
		add_in = op;
		next_cycle();
		while (!add_taken && !timed_out) begin
			if (tries == RETRY_LIMIT) begin
				note_timeout("retrying an add/sub issue");
			end else begin
				tries++;
				next_cycle();
			end
		end
		add_in = '0;
	endtask

	task automatic offer_mov(input issue_t op);
		int tries = 0;
		mov_in = op;
		next_cycle();
		while (!mov_taken && !timed_out) begin
			if (tries == RETRY_LIMIT) begin
				note_timeout("retrying a move issue");
			end else begin
				tries++;
				next_cycle();
			end
		end
		mov_in = '0;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests++;
		if (test_errors == 0) begin
			$display("%s: passed", test_name);
		end else begin
			$display("%s: %0d errors", test_name, test_errors);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic single_issues();
		begin_test("single_issues");
		mul_in = make_issue(4'h1, 1'b0, 32'h1234_5678, 32'h9abc_def0);
		next_cycle();
		drain();
		offer_add(make_issue(4'h2, 1'b1, 32'h0000_0005, 32'h0000_0007));
		drain();
		offer_mov(make_issue(4'h3, 1'b0, 32'h5a5a_1234, 32'h0));
		drain();
		end_test();
	endtask

	// mul issued on edge k owns the cycle that add would claim on k + 2
	task automatic add_after_mul();
		begin_test("add_after_mul");
		mul_in = make_issue(4'h4, 1'b0, 32'hffff_ffff, 32'h0000_0003);
		next_cycle();
		mul_in = '0;
		next_cycle();
		check_ready("add_ready behind mul", 1'b0, add_ready);
		offer_add(make_issue(4'h5, 1'b0, 32'h8000_0000, 32'h8000_0001));
		drain();
		end_test();
	endtask

	task automatic mov_collisions();
		begin_test("mov_collisions");
		mul_in = make_issue(4'h6, 1'b0, 32'h0001_0001, 32'h0002_0003);
		next_cycle();
		mul_in = '0;
		repeat (`MUL_LATENCY - 2) next_cycle();
		check_ready("mov_ready behind mul", 1'b0, mov_ready);
		offer_mov(make_issue(4'h7, 1'b0, 32'h0000_00aa, 32'h0));
		drain();
		add_in = make_issue(4'h8, 1'b1, 32'h0000_0000, 32'h0000_0001);
		next_cycle();
		add_in = '0;
		check_ready("mov_ready behind add", 1'b0, mov_ready);
		offer_mov(make_issue(4'h9, 1'b0, 32'h0000_00bb, 32'h0));
		drain();
		check_ready("add_ready when idle", 1'b1, add_ready);
		check_ready("mov_ready when idle", 1'b1, mov_ready);
		mul_in = make_issue(4'ha, 1'b0, 32'h0000_1000, 32'h0000_2000);
		add_in = make_issue(4'hb, 1'b0, 32'h7fff_ffff, 32'h0000_0001);
		mov_in = make_issue(4'hc, 1'b0, 32'h0000_00cc, 32'h0);
		next_cycle();
		drain();
		end_test();
	endtask

	task automatic mul_stream();
		begin_test("mul_stream");
		for (int i = 0; i < 6; i++) begin
			mul_in = make_issue(tag_t'(i), 1'b0, $urandom, $urandom);
			next_cycle();
		end
		drain();
		end_test();
	endtask

	task automatic flush_in_flight();
		begin_test("flush_in_flight");
		mul_in = make_issue(4'h1, 1'b0, $urandom, $urandom);
		add_in = make_issue(4'h2, 1'b0, $urandom, $urandom);
		next_cycle();
		clear_inputs();
		mul_in = make_issue(4'h3, 1'b0, $urandom, $urandom);
		next_cycle();
		// new issues on the flush edge are dropped too
		flush  = 1'b1;
		mul_in = make_issue(4'h4, 1'b0, $urandom, $urandom);
		mov_in = make_issue(4'h5, 1'b0, $urandom, $urandom);
		next_cycle();
		flush = 1'b0;
		clear_inputs();
		check_ready("add_ready after flush", 1'b1, add_ready);
		check_ready("mov_ready after flush", 1'b1, mov_ready);
		repeat (`MUL_LATENCY) next_cycle();
		mul_in = make_issue(4'h6, 1'b0, $urandom, $urandom);
		add_in = make_issue(4'h7, 1'b1, $urandom, $urandom);
		mov_in = make_issue(4'h8, 1'b0, $urandom, $urandom);
		next_cycle();
		drain();
		end_test();
	endtask

	task automatic random_mix(input int n_cycles);
		begin_test("random_mix");
		for (int i = 0; i < n_cycles && !timed_out; i++) begin
			mul_in = '0;
			if ($urandom_range(2, 0) == 0) begin
				mul_in = random_issue();
			end
			if (add_taken || !add_in.valid) begin
				add_in = ($urandom_range(1, 0) == 1) ? random_issue() : '0;
			end
			if (mov_taken || !mov_in.valid) begin
				mov_in = ($urandom_range(1, 0) == 1) ? random_issue() : '0;
			end
			next_cycle();
		end
		drain();
		end_test();
	endtask

	initial begin
		void'($urandom(32'ha3c3));
		reset       = 1'b1;
		flush       = 1'b0;
		clear_inputs();
		cycle       = 0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		test_errors = 0;
		timed_out   = 1'b0;
		test_name   = "reset";
		repeat (5) @(negedge clk);
		reset = 1'b0;
		single_issues();
		add_after_mul();
		mov_collisions();
		mul_stream();
		flush_in_flight();
		random_mix(400);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

`default_nettype wire

// ==== wb_sched/wb_reservation.sv ====
`include "wb_macros.svh"
`default_nettype none

module wb_reservation
	import wb_pkg::*;
	import issue_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,
	input  issue_t     mul_issue,
	input  issue_t     add_issue,
	input  issue_t     mov_issue,
	output logic       add_ready,
	output logic       mov_ready,
	output rsv_entry_t head
);
	// entry 0 is the bus cycle right now, entry n is n cycles ahead
	localparam int MUL_SLOT = `MUL_LATENCY - 1;
	localparam int ADD_SLOT = `ADD_LATENCY - 1;
	localparam int MOV_SLOT = `MOV_LATENCY - 1;
	localparam int TOP = `RSV_DEPTH - 1;

	rsv_entry_t [`RSV_DEPTH-1:0] rsv;
	rsv_entry_t [`RSV_DEPTH-1:0] rsv_next;
	logic                        mul_accept;
	logic                        add_accept;
	logic                        mov_accept;

	function automatic rsv_entry_t make_entry(input tag_t tag, input wb_src_t src);
		rsv_entry_t entry;
		entry.valid = 1'b1;
		entry.tag   = tag;
		entry.src   = src;
		return entry;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// acceptance
	//////////////////////////////////////////////////////////////////////

	// a slot is free if nothing shifts into it on this edge
	assign add_ready = !rsv[ADD_SLOT + 1].valid;
	assign mov_ready = !rsv[MOV_SLOT + 1].valid;

	// the slowest unit always finds its slot empty
	assign mul_accept = mul_issue.valid;
	assign add_accept = add_issue.valid && add_ready;
	assign mov_accept = mov_issue.valid && mov_ready;

	//////////////////////////////////////////////////////////////////////
	// shift chain
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < TOP; i++) begin
			rsv_next[i] = rsv[i + 1];
		end
		rsv_next[TOP] = '0;

		// latencies differ, so same-edge writes never share a slot
		if (mul_accept) begin
			rsv_next[MUL_SLOT] = make_entry(mul_issue.tag, SRC_MUL);
		end
		if (add_accept) begin
			rsv_next[ADD_SLOT] = make_entry(add_issue.tag, SRC_ADD_SUB);
		end
		if (mov_accept) begin
			rsv_next[MOV_SLOT] = make_entry(mov_issue.tag, SRC_MOV);
		end
	end

	// flush drops everything in flight, including this edge's issues
	always_ff @(posedge clk) begin
		rsv <= rsv_next;
		if (reset || flush) begin
			for (int i = 0; i < `RSV_DEPTH; i++) begin
				rsv[i].valid <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////////////////////////

	// owner of the current bus cycle
	assign head = rsv[0];
endmodule

`default_nettype wire
